// File: rtl/decomp_pkg.sv
/*
  Shared geometry, word types and link structs for the frame pipeline.
  One frame is FRAME_WORDS pixels; the input and output regions must not overlap.
  The memory word is read as a ycc sample in the input region and as rgb565 in the output.
*/

package decomp_pkg;

	// Memory geometry
	localparam int ADDR_W      = 8;
	localparam int STORE_DEPTH = 256;
	localparam int FRAME_WORDS = 64;
	localparam int CNT_W       = $clog2(FRAME_WORDS);   // Pixel index width

	localparam logic [ADDR_W-1:0] IN_BASE  = 8'd0;
	localparam logic [ADDR_W-1:0] OUT_BASE = 8'd128;

	// Compressed luma/chroma sample
	typedef struct packed {
		logic [7:0]        y;
		logic signed [3:0] cb;
		logic signed [3:0] cr;
	} ycc_t;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	// One memory word, two readings
	typedef union packed {
		ycc_t    ycc;
		rgb565_t pixel;
	} store_word_u;

	// Request from a peer toward the memory port
	typedef struct packed {
		logic              valid;
		logic              we;     // High for a write
		logic [ADDR_W-1:0] addr;
		store_word_u       wdata;
	} mem_req_t;

	typedef struct packed {
		logic        grant;    // Same cycle as the request
		logic        rvalid;   // One cycle after a granted read
		store_word_u rdata;
	} mem_rsp_t;

	// Top sequencer phases
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_LOAD,
		PH_CONVERT,
		PH_READOUT
	} phase_e;

endpackage

// File: rtl/sample_store.sv
/*
  Single-port synchronous word memory, STORE_DEPTH words.
  Read data appears one cycle after a read request and holds until the next read.
  Array contents are undefined until written.
*/

`timescale 1ns/1ns

module sample_store
	import decomp_pkg::*;
(
	input  logic        CLOCK_50_I,
	input  mem_req_t    req,
	output store_word_u rdata
);

	store_word_u mem [STORE_DEPTH];

	always_ff @(posedge CLOCK_50_I) begin
		if (req.valid) begin
			if (req.we) begin
				mem[req.addr] <= req.wdata;
			end else begin
				rdata <= mem[req.addr];   // One-cycle read latency
			end
		end
	end

endmodule

// File: rtl/store_arbiter.sv
/*
  Fixed-priority arbiter for the single memory port: loader, converter, reader.
  Grant is combinational in the request cycle; a requester holds until granted.
  Read data returns to the owner of the read one cycle later.
*/

`timescale 1ns/1ns

module store_arbiter
	import decomp_pkg::*;
(
	input  logic        CLOCK_50_I,
	input  logic        resetn,
	input  mem_req_t    load_req,
	input  mem_req_t    conv_req,
	input  mem_req_t    read_req,
	output mem_rsp_t    load_rsp,
	output mem_rsp_t    conv_rsp,
	output mem_rsp_t    read_rsp,
	output mem_req_t    store_req,
	input  store_word_u store_rdata
);

	logic [2:0] grant;      // One-hot with the loader in bit 0
	logic [2:0] rd_owner;   // Who owns the read in flight

	assign grant[0] = load_req.valid;
	assign grant[1] = conv_req.valid & ~load_req.valid;
	assign grant[2] = read_req.valid & ~load_req.valid & ~conv_req.valid;

	// Forward the winner to the memory
	always_comb begin
		if (grant[0]) begin
			store_req = load_req;
		end else if (grant[1]) begin
			store_req = conv_req;
		end else if (grant[2]) begin
			store_req = read_req;
		end else begin
			store_req = '0;   // Port idle
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (~resetn) begin
			rd_owner <= '0;
		end else begin
			rd_owner <= grant & {3{~store_req.we}};   // Writes leave no owner
		end
	end

	always_comb begin
		load_rsp.grant  = grant[0];
		load_rsp.rvalid = rd_owner[0];
		load_rsp.rdata  = store_rdata;
		conv_rsp.grant  = grant[1];
		conv_rsp.rvalid = rd_owner[1];
		conv_rsp.rdata  = store_rdata;
		read_rsp.grant  = grant[2];
		read_rsp.rvalid = rd_owner[2];
		read_rsp.rdata  = store_rdata;
	end

endmodule

// File: rtl/stream_loader.sv
/*
  Writes one input frame of ycc words to IN_BASE onward, one word per accepted beat.
  in_ready follows the write grant, so it may depend on in_valid in the same cycle.
  done pulses one cycle after the last word; the word count then starts again at zero.
*/

`timescale 1ns/1ns

module stream_loader
	import decomp_pkg::*;
(
	input  logic     CLOCK_50_I,
	input  logic     resetn,
	input  logic     enable,
	input  logic     in_valid,
	input  ycc_t     in_data,
	output logic     in_ready,
	output mem_req_t req,
	input  mem_rsp_t rsp,
	output logic     done
);

	logic [CNT_W-1:0] count;   // Words written so far

	always_comb begin
		req.valid      = enable & in_valid & ~done;   // Quiet while the phase closes
		req.we         = 1'b1;
		req.addr       = IN_BASE + ADDR_W'(count);
		req.wdata.ycc  = in_data;
	end

	assign in_ready = enable & rsp.grant;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (~resetn) begin
			count <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			if (in_valid & in_ready) begin
				count <= count + 1'b1;   // Wraps to zero after the last word
				if (count == CNT_W'(FRAME_WORDS - 1)) begin
					done <= 1'b1;
				end
			end
		end
	end

endmodule

// File: rtl/color_convert.sv
/*
  Converts each stored ycc word to rgb565 and writes it to OUT_BASE plus the index.
  A pixel is one granted read then one granted write, so at best two cycles per pixel.
  Channels are clipped to 0..255 before truncation to 5/6/5 bits.
  done pulses one cycle after the last write.
*/

`timescale 1ns/1ns

module color_convert
	import decomp_pkg::*;
(
	input  logic     CLOCK_50_I,
	input  logic     resetn,
	input  logic     enable,
	output mem_req_t req,
	input  mem_rsp_t rsp,
	output logic     done
);

	typedef enum logic {
		ST_READ,
		ST_WRITE
	} conv_state_e;

	conv_state_e      state;
	logic [CNT_W-1:0] idx;    // Pixel index
	store_word_u      held;   // Read word kept while the write waits
	ycc_t             src;
	logic signed [9:0] y_s, cb_s, cr_s;
	logic signed [9:0] r_s, g_s, b_s;
	logic [7:0]       r8, g8, b8;
	rgb565_t          pix;

	// Saturate a channel to the 8-bit range
	function automatic logic [7:0] clip8(input logic signed [9:0] v);
		logic [7:0] res;
		if (v < 0) begin
			res = 8'd0;
		end else if (v > 10'sd255) begin
			res = 8'd255;
		end else begin
			res = v[7:0];
		end
		return res;
	endfunction

	always_comb begin
		src  = rsp.rvalid ? rsp.rdata.ycc : held.ycc;   // Fresh data on the first write try
		y_s  = {2'b00, src.y};
		cb_s = {{6{src.cb[3]}}, src.cb};
		cr_s = {{6{src.cr[3]}}, src.cr};
		r_s  = y_s + cr_s + cr_s;
		g_s  = y_s - cb_s - cr_s;
		b_s  = y_s + cb_s + cb_s;
		r8   = clip8(r_s);
		g8   = clip8(g_s);
		b8   = clip8(b_s);
		pix.r = r8[7:3];
		pix.g = g8[7:2];
		pix.b = b8[7:3];
	end

	always_comb begin
		req.valid       = enable & ~done;
		req.we          = (state == ST_WRITE);
		req.addr        = (state == ST_WRITE) ? OUT_BASE + ADDR_W'(idx)
		                                      : IN_BASE + ADDR_W'(idx);
		req.wdata.pixel = pix;
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (~resetn) begin
			state <= ST_READ;
			idx   <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			if (rsp.grant) begin
				if (state == ST_READ) begin
					state <= ST_WRITE;
				end else begin
					state <= ST_READ;
					idx   <= idx + 1'b1;   // Back to zero after the frame
					if (idx == CNT_W'(FRAME_WORDS - 1)) begin
						done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (rsp.rvalid) begin
			held <= rsp.rdata;
		end
	end

endmodule

// File: rtl/frame_reader.sv
/*
  Streams the output region in address order through a one-entry output register.
  A read is issued only when the register is empty or being taken this cycle.
  out_pixel holds while out_valid is high and out_ready is low.
*/

`timescale 1ns/1ns

module frame_reader
	import decomp_pkg::*;
(
	input  logic     CLOCK_50_I,
	input  logic     resetn,
	input  logic     enable,
	output mem_req_t req,
	input  mem_rsp_t rsp,
	output logic     out_valid,
	output rgb565_t  out_pixel,
	input  logic     out_ready,
	output logic     done
);

	logic [CNT_W:0]   rd_cnt;    // Reads issued, up to FRAME_WORDS
	logic [CNT_W-1:0] out_cnt;   // Pixels accepted downstream
	logic             pending;   // Read granted, data not back yet
	logic             take;

	assign take = out_valid & out_ready;

	always_comb begin
		req       = '0;
		req.valid = enable & ~done & ~pending
		            & (rd_cnt < (CNT_W + 1)'(FRAME_WORDS))
		            & (~out_valid | out_ready);
		req.addr  = OUT_BASE + ADDR_W'(rd_cnt[CNT_W-1:0]);
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (~resetn) begin
			rd_cnt    <= '0;
			out_cnt   <= '0;
			pending   <= 1'b0;
			out_valid <= 1'b0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			if (rsp.rvalid) pending <= 1'b0;
			if (rsp.grant) begin
				pending <= 1'b1;
				rd_cnt  <= rd_cnt + 1'b1;
			end
			if (rsp.rvalid) begin
				out_valid <= 1'b1;
			end else if (take) begin
				out_valid <= 1'b0;
			end
			if (take) begin
				out_cnt <= out_cnt + 1'b1;
				if (out_cnt == CNT_W'(FRAME_WORDS - 1)) begin
					done   <= 1'b1;
					rd_cnt <= '0;   // Ready for the next frame
				end
			end
		end
	end

	// Output register, loaded only when empty or emptying
	always_ff @(posedge CLOCK_50_I) begin
		if (rsp.rvalid) begin
			out_pixel <= rsp.rdata.pixel;
		end
	end

endmodule

// File: rtl/image_decompressor.sv
/*
  Top level: phase sequencer plus loader, converter and reader on one shared memory.
  start is only seen in PH_IDLE; busy stays high until the last pixel is accepted.
  Each unit is enabled only during its own phase.
*/

`timescale 1ns/1ns

module image_decompressor
	import decomp_pkg::*;
(
	input  logic    CLOCK_50_I,
	input  logic    resetn,
	input  logic    start,
	output logic    busy,
	input  logic    in_valid,
	input  ycc_t    in_data,
	output logic    in_ready,
	output logic    out_valid,
	output rgb565_t out_pixel,
	input  logic    out_ready
);

	phase_e      phase;
	logic        load_en, conv_en, read_en;
	logic        load_done, conv_done, read_done;
	mem_req_t    load_req, conv_req, read_req;
	mem_rsp_t    load_rsp, conv_rsp, read_rsp;
	mem_req_t    store_req;
	store_word_u store_rdata;

	assign load_en = (phase == PH_LOAD);
	assign conv_en = (phase == PH_CONVERT);
	assign read_en = (phase == PH_READOUT);
	assign busy    = (phase != PH_IDLE);

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (~resetn) begin
			phase <= PH_IDLE;
		end else begin
			case (phase)
				PH_IDLE:    if (start) phase <= PH_LOAD;
				PH_LOAD:    if (load_done) phase <= PH_CONVERT;
				PH_CONVERT: if (conv_done) phase <= PH_READOUT;
				PH_READOUT: if (read_done) phase <= PH_IDLE;
				default:    phase <= PH_IDLE;
			endcase
		end
	end

	stream_loader i_stream_loader (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.enable     (load_en),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_ready   (in_ready),
		.req        (load_req),
		.rsp        (load_rsp),
		.done       (load_done)
	);

	color_convert i_color_convert (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.enable     (conv_en),
		.req        (conv_req),
		.rsp        (conv_rsp),
		.done       (conv_done)
	);

	frame_reader i_frame_reader (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.enable     (read_en),
		.req        (read_req),
		.rsp        (read_rsp),
		.out_valid  (out_valid),
		.out_pixel  (out_pixel),
		.out_ready  (out_ready),
		.done       (read_done)
	);

	store_arbiter i_store_arbiter (
		.CLOCK_50_I  (CLOCK_50_I),
		.resetn      (resetn),
		.load_req    (load_req),
		.conv_req    (conv_req),
		.read_req    (read_req),
		.load_rsp    (load_rsp),
		.conv_rsp    (conv_rsp),
		.read_rsp    (read_rsp),
		.store_req   (store_req),
		.store_rdata (store_rdata)
	);

	sample_store i_sample_store (
		.CLOCK_50_I (CLOCK_50_I),
		.req        (store_req),
		.rdata      (store_rdata)
	);

endmodule

// File: verification/tb_image_decompressor.sv
/*
  Testbench for the frame pipeline: random and corner ycc frames in, rgb565 pixels out.
  Expected pixels come from a model of the conversion rule and are compared in order.
  Fixed seed, so every run drives the same stimulus and back-pressure.
*/

`timescale 1ns/1ns

module tb_image_decompressor
	import decomp_pkg::*;
();

	localparam int WATCHDOG_CYCLES = 2 * FRAME_WORDS * 40 + 1000;   // Two frames plus margin

	logic    CLOCK_50_I = 1'b0;
	logic    resetn;
	logic    start;
	logic    busy;
	logic    in_valid;
	ycc_t    in_data;
	logic    in_ready;
	logic    out_valid;
	rgb565_t out_pixel;
	logic    out_ready;

	int      seed = 90725;
	int      checks = 0;
	int      mismatches = 0;
	int      failures = 0;
	ycc_t    frame_q[$];    // Words of the next frame
	rgb565_t expect_q[$];   // Model pixels still to come out

	image_decompressor i_image_decompressor (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.start      (start),
		.busy       (busy),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_pixel  (out_pixel),
		.out_ready  (out_ready)
	);

	always #20 CLOCK_50_I = ~CLOCK_50_I;

	function automatic int roll_percent();
		int v;
		v = $random(seed) & 32'h7fff_ffff;
		return v % 100;
	endfunction

	function automatic int clip_byte(input int v);
		if (v < 0) begin
			return 0;
		end else if (v > 255) begin
			return 255;
		end
		return v;
	endfunction

	// Reference rgb565 for one ycc word with channels clipped to 0..255
	function automatic rgb565_t expected_pixel(input ycc_t w);
		int      y;
		int      cb;
		int      cr;
		rgb565_t p;
		y   = int'(w.y);
		cb  = int'($signed(w.cb));
		cr  = int'($signed(w.cr));
		p.r = 5'(clip_byte(y + 2 * cr) >> 3);
		p.g = 6'(clip_byte(y - cb - cr) >> 2);
		p.b = 5'(clip_byte(y + 2 * cb) >> 3);
		return p;
	endfunction

	task automatic check_pixel(input string name, input rgb565_t got, input rgb565_t exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got r=%h g=%h b=%h, expected r=%h g=%h b=%h at %0t",
			         name, got.r, got.g, got.b, exp.r, exp.g, exp.b, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic make_random_frame();
		logic [31:0] r;
		frame_q.delete();
		for (int i = 0; i < FRAME_WORDS; i++) begin
			r = $random(seed);
			frame_q.push_back(r[15:0]);
		end
	endtask

	// Every mix of low/high luma with chroma -8, 0, +7, -1
	task automatic make_corner_frame();
		logic [7:0] y_tab [4];
		logic [3:0] c_tab [4];
		logic [5:0] k;
		ycc_t       w;
		y_tab = '{8'h00, 8'h04, 8'hfb, 8'hff};
		c_tab = '{4'h8, 4'h0, 4'h7, 4'hf};
		frame_q.delete();
		for (int i = 0; i < FRAME_WORDS; i++) begin
			k    = i[5:0];
			w.y  = y_tab[k[1:0]];
			w.cb = c_tab[k[3:2]];
			w.cr = c_tab[k[5:4]];
			frame_q.push_back(w);
		end
	endtask

	task automatic send_frame(input int gap_pct);
		int sent;
		sent = 0;
		while (sent < FRAME_WORDS) begin
			@(posedge CLOCK_50_I);
			if (roll_percent() < gap_pct) begin
				in_valid <= 1'b0;   // Gap beat
			end else begin
				in_valid <= 1'b1;
				in_data  <= frame_q[sent];
			end
			@(negedge CLOCK_50_I);
			check_bit("in_ready", in_ready, in_valid);   // Loader owns the port here
			if (in_valid && in_ready) begin
				sent++;
			end
		end
		@(posedge CLOCK_50_I);
		in_valid <= 1'b0;
	endtask

	task automatic receive_frame(input int stall_pct);
		int      got;
		logic    stalled;
		rgb565_t held;
		got     = 0;
		stalled = 1'b0;
		held    = '0;
		while (got < FRAME_WORDS) begin
			@(posedge CLOCK_50_I);
			out_ready <= (roll_percent() >= stall_pct);
			@(negedge CLOCK_50_I);
			check_bit("busy", busy, 1'b1);
			if (stalled) begin
				check_bit("out_valid held", out_valid, 1'b1);
				check_pixel("out_pixel held", out_pixel, held);
			end
			if (out_valid && out_ready) begin
				if (expect_q.size() == 0) begin
					failures++;
					$display("Pixel accepted with no expected pixel left at %0t", $time);
				end else begin
					check_pixel("out_pixel", out_pixel, expect_q.pop_front());
				end
				got++;
			end
			stalled = out_valid && !out_ready;
			held    = out_pixel;
		end
		@(posedge CLOCK_50_I);
		out_ready <= 1'b0;
	endtask

	task automatic run_frame(input int gap_pct, input int stall_pct);
		int wait_cycles;
		foreach (frame_q[i]) begin
			expect_q.push_back(expected_pixel(frame_q[i]));
		end
		@(posedge CLOCK_50_I);
		start <= 1'b1;
		@(posedge CLOCK_50_I);
		start <= 1'b0;
		fork
			send_frame(gap_pct);
			receive_frame(stall_pct);
		join
		wait_cycles = 0;
		@(negedge CLOCK_50_I);
		while (busy && wait_cycles < 8) begin
			@(negedge CLOCK_50_I);
			wait_cycles++;
		end
		if (busy) begin
			failures++;
			$display("busy still high %0d cycles after the last pixel", wait_cycles);
		end
		repeat (4) begin
			@(negedge CLOCK_50_I);
			check_bit("out_valid after frame", out_valid, 1'b0);   // Nothing repeated
		end
		if (expect_q.size() != 0) begin
			failures++;
			$display("%0d expected pixels never came out", expect_q.size());
		end
	endtask

	initial begin
		resetn    <= 1'b0;
		start     <= 1'b0;
		in_valid  <= 1'b0;
		in_data   <= '0;
		out_ready <= 1'b0;
		repeat (16) @(posedge CLOCK_50_I);
		resetn <= 1'b1;
		// Valid and ready offered without start
		@(posedge CLOCK_50_I);
		in_valid  <= 1'b1;
		out_ready <= 1'b1;
		repeat (8) begin
			@(negedge CLOCK_50_I);
			check_bit("busy", busy, 1'b0);
			check_bit("in_ready", in_ready, 1'b0);
			check_bit("out_valid", out_valid, 1'b0);
		end
		@(posedge CLOCK_50_I);
		in_valid  <= 1'b0;
		out_ready <= 1'b0;

		make_random_frame();
		run_frame(30, 20);
		make_corner_frame();
		run_frame(10, 60);   // Heavier back-pressure

		$display("Checks: %0d, mismatches: %0d, other failures: %0d",
		         checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50_I);
		$display("Timeout after %0d cycles, frames did not complete (%0d mismatches so far)",
		         WATCHDOG_CYCLES, mismatches);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: files.f
rtl/decomp_pkg.sv
rtl/sample_store.sv
rtl/store_arbiter.sv
rtl/stream_loader.sv
rtl/color_convert.sv
rtl/frame_reader.sv
rtl/image_decompressor.sv
verification/tb_image_decompressor.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and decide from its output
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_image_decompressor -f files.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1
